// File: project.f
mem_pkg.sv
lsq_pkg.sv
sq_lq_if.sv
queue_ptrs.sv
store_forward.sv
store_queue.sv
load_queue.sv
lsq_top.sv
lsq_tb.sv

// File: lsq_tb.sv
`timescale 1ns/1ns

module lsq_tb;
  import mem_pkg::*;

  localparam int SQ_DEPTH = 8;
  localparam int LQ_DEPTH = 8;
  localparam int READY_TIMEOUT = 50;
  localparam addr_t ADDR_BASE = 61'h8;

  typedef struct {
    int    seq;
    addr_t addr;
    data_t data;
    bit    executed;
  } shadow_store_t;

  typedef struct {
    int    seq;
    addr_t pc;
    int    bound;
    addr_t addr;
    bit    executed;
    bit    forwarded;
    int    src_seq;
  } shadow_load_t;

  typedef struct {
    data_t data;
    bit    forwarded;
    int    src_seq;
  } load_result_t;

  typedef struct {
    bit    hit;
    addr_t pc;
  } violation_t;

  logic                        clock;
  logic                        reset;
  logic                        dispatch_valid;
  mem_op_e                     dispatch_op;
  addr_t                       dispatch_pc;
  logic                        dispatch_ready;
  logic [$clog2(SQ_DEPTH)-1:0] sq_idx;
  logic [$clog2(LQ_DEPTH)-1:0] lq_idx;
  logic                        st_exec;
  logic [$clog2(SQ_DEPTH)-1:0] st_exec_idx;
  addr_t                       st_addr;
  data_t                       st_data;
  logic                        ld_exec;
  logic [$clog2(LQ_DEPTH)-1:0] ld_exec_idx;
  addr_t                       ld_addr;
  logic                        ld_done;
  data_t                       ld_data;
  logic                        ld_forwarded;
  logic                        mem_rd_en;
  addr_t                       mem_rd_addr;
  data_t                       mem_rd_data;
  logic                        store_retire;
  logic                        load_retire;
  logic                        mem_wr_en;
  addr_t                       mem_wr_addr;
  data_t                       mem_wr_data;
  logic                        violation;
  addr_t                       violation_pc;

  // DUT memory and the model's own copy of it
  data_t mem [16];
  data_t ref_mem [16];

  shadow_store_t stores [$];
  shadow_load_t  loads [$];
  int            store_count = 0;
  int            load_count = 0;
  int            check_count = 0;
  int            error_count = 0;
  int            test_first_check;
  int            test_first_error;
  string         test_name = "startup";

  lsq_top lsq_top_inst (.*);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  assign mem_rd_data = mem[mem_rd_addr[3:0]];

  always @(posedge clock) begin
    if (mem_wr_en) begin
      mem[mem_wr_addr[3:0]] <= mem_wr_data;
    end
  end

  function automatic data_t fill_word(int a);
    return {32'(a) * 32'h9e37_79b9, 32'hc0de_0000 + 32'(a)};
  endfunction

  function automatic addr_t random_addr();
    return ADDR_BASE + addr_t'($urandom_range(3));
  endfunction

  function automatic int find_load(int idx);
    foreach (loads[i]) begin
      if (loads[i].seq % LQ_DEPTH == idx) begin
        return i;
      end
    end
    return -1;
  endfunction

  // Youngest older executed store wins over memory
  function automatic load_result_t expected_load(int bound, addr_t addr);
    load_result_t r;
    r.forwarded = 1'b0;
    r.data      = ref_mem[addr[3:0]];
    r.src_seq   = -1;
    foreach (stores[i]) begin
      if (stores[i].seq < bound && stores[i].executed && stores[i].addr == addr) begin
        r.forwarded = 1'b1;
        r.data      = stores[i].data;
        r.src_seq   = stores[i].seq;
      end
    end
    return r;
  endfunction

  // Oldest executed load whose boundary is not the retiring store
  function automatic violation_t expected_violation();
    violation_t v;
    v.hit = 1'b0;
    v.pc  = '0;
    foreach (loads[i]) begin
      if (!v.hit && loads[i].bound != stores[0].seq && loads[i].executed &&
          loads[i].addr == stores[0].addr &&
          !(loads[i].forwarded && loads[i].src_seq == stores[0].seq)) begin
        v.hit = 1'b1;
        v.pc  = loads[i].pc;
      end
    end
    return v;
  endfunction

  task automatic check_value(string what, logic [63:0] expected, logic [63:0] actual);
    check_count++;
    assert (actual === expected) else begin
      $display("[ERROR] %s: %s expected %0h, actual %0h", test_name, what, expected, actual);
      error_count++;
    end
  endtask

  task automatic start_test(string name);
    test_name        = name;
    test_first_check = check_count;
    test_first_error = error_count;
  endtask

  task automatic end_test();
    $display("Test %s finished: %0d checks, %0d errors", test_name,
             check_count - test_first_check, error_count - test_first_error);
  endtask

  task automatic end_run();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  endtask

  task automatic wait_ready();
    int waited;
    waited = 0;
    @(negedge clock);
    while (!dispatch_ready && waited < READY_TIMEOUT) begin
      @(negedge clock);
      waited++;
    end
    if (!dispatch_ready) begin
      $display("Timed out in %s waiting for dispatch_ready", test_name);
      error_count++;
      end_run();
    end
  endtask

  task automatic dispatch(mem_op_e op, addr_t pc);
    wait_ready();
    @(posedge clock);
    dispatch_valid <= 1'b1;
    dispatch_op    <= op;
    dispatch_pc    <= pc;
    @(posedge clock);
    dispatch_valid <= 1'b0;
    dispatch_op    <= op_none;
    if (op == op_store) begin
      stores.push_back('{seq: store_count, addr: '0, data: '0, executed: 1'b0});
      store_count++;
    end else begin
      loads.push_back('{seq: load_count, pc: pc, bound: store_count, addr: '0,
                        executed: 1'b0, forwarded: 1'b0, src_seq: -1});
      load_count++;
    end
  endtask

  task automatic exec_store(int seq, addr_t addr, data_t data);
    @(posedge clock);
    st_exec     <= 1'b1;
    st_exec_idx <= seq % SQ_DEPTH;
    st_addr     <= addr;
    st_data     <= data;
    @(posedge clock);
    st_exec <= 1'b0;
    foreach (stores[i]) begin
      if (stores[i].seq == seq) begin
        stores[i].addr     = addr;
        stores[i].data     = data;
        stores[i].executed = 1'b1;
      end
    end
  endtask

  task automatic exec_load(int seq, addr_t addr);
    load_result_t r;
    int           pos;
    @(posedge clock);
    ld_exec     <= 1'b1;
    ld_exec_idx <= seq % LQ_DEPTH;
    ld_addr     <= addr;
    @(posedge clock);
    ld_exec <= 1'b0;
    pos = find_load(seq % LQ_DEPTH);
    r = expected_load(loads[pos].bound, addr);
    loads[pos].addr      = addr;
    loads[pos].executed  = 1'b1;
    loads[pos].forwarded = r.forwarded;
    loads[pos].src_seq   = r.src_seq;
  endtask

  task automatic retire_store();
    @(posedge clock);
    store_retire <= 1'b1;
    @(posedge clock);
    store_retire <= 1'b0;
    ref_mem[stores[0].addr[3:0]] = stores[0].data;
    void'(stores.pop_front());
  endtask

  task automatic retire_load();
    @(posedge clock);
    load_retire <= 1'b1;
    @(posedge clock);
    load_retire <= 1'b0;
    void'(loads.pop_front());
  endtask

  // Outputs are settled by the falling edge
  always @(negedge clock) begin
    load_result_t lr;
    violation_t   vr;
    int           pos;
    if (!reset) begin
      if (dispatch_valid && dispatch_op == op_store) begin
        check_value("sq_idx", store_count % SQ_DEPTH, sq_idx);
      end
      if (dispatch_valid && dispatch_op == op_load) begin
        check_value("lq_idx", load_count % LQ_DEPTH, lq_idx);
      end
      check_value("ld_done", ld_exec, ld_done);
      if (ld_exec) begin
        pos = find_load(ld_exec_idx);
        assert (pos >= 0) else begin
          $display("%s: load executed on an entry that was never dispatched", test_name);
          error_count++;
        end
        if (pos >= 0) begin
          lr = expected_load(loads[pos].bound, ld_addr);
          check_value("ld_forwarded", lr.forwarded, ld_forwarded);
          check_value("ld_data", lr.data, ld_data);
          check_value("mem_rd_en", !lr.forwarded, mem_rd_en);
          if (!lr.forwarded) begin
            check_value("mem_rd_addr", ld_addr, mem_rd_addr);
          end
        end
      end else begin
        check_value("mem_rd_en idle", 0, mem_rd_en);
      end
      if (store_retire) begin
        assert (stores.size() != 0) else begin
          $display("%s: store retired with no store in the queue", test_name);
          error_count++;
        end
        if (stores.size() != 0) begin
          vr = expected_violation();
          check_value("mem_wr_en", 1, mem_wr_en);
          check_value("mem_wr_addr", stores[0].addr, mem_wr_addr);
          check_value("mem_wr_data", stores[0].data, mem_wr_data);
          check_value("violation", vr.hit, violation);
          if (vr.hit) begin
            check_value("violation_pc", vr.pc, violation_pc);
          end
        end
      end else begin
        check_value("mem_wr_en idle", 0, mem_wr_en);
        check_value("violation idle", 0, violation);
      end
    end
  end

  initial begin
    int    s0;
    int    l0;
    addr_t a;
    void'($urandom(32'h6088));
    reset          <= 1'b1;
    dispatch_valid <= 1'b0;
    dispatch_op    <= op_none;
    dispatch_pc    <= '0;
    st_exec        <= 1'b0;
    st_exec_idx    <= '0;
    st_addr        <= '0;
    st_data        <= '0;
    ld_exec        <= 1'b0;
    ld_exec_idx    <= '0;
    ld_addr        <= '0;
    store_retire   <= 1'b0;
    load_retire    <= 1'b0;
    for (int i = 0; i < 16; i++) begin
      mem[i]     = fill_word(i);
      ref_mem[i] = fill_word(i);
    end
    repeat (16) @(posedge clock);
    reset <= 1'b0;

    start_test("reset_state");
    @(negedge clock);
    check_value("dispatch_ready", 1, dispatch_ready);
    check_value("ld_done", 0, ld_done);
    check_value("mem_rd_en", 0, mem_rd_en);
    check_value("mem_wr_en", 0, mem_wr_en);
    check_value("violation", 0, violation);
    end_test();

    start_test("dispatch_order");
    for (int i = 0; i < 3; i++) begin
      dispatch(op_load, 61'h100 + i);
    end
    for (int i = 0; i < 3; i++) begin
      retire_load();
    end
    s0 = store_count;
    for (int i = 0; i < SQ_DEPTH; i++) begin
      dispatch(op_store, 61'h200 + i);
    end
    @(negedge clock);
    check_value("dispatch_ready with SQ full", 0, dispatch_ready);
    for (int i = 0; i < SQ_DEPTH; i++) begin
      exec_store(s0 + i, random_addr(), {$urandom, $urandom});
    end
    retire_store();
    @(negedge clock);
    check_value("dispatch_ready after retire", 1, dispatch_ready);
    for (int i = 1; i < SQ_DEPTH; i++) begin
      retire_store();
    end
    end_test();

    start_test("load_from_memory");
    for (int i = 0; i < 3; i++) begin
      l0 = load_count;
      dispatch(op_load, 61'h300 + i);
      exec_load(l0, random_addr());
      retire_load();
    end
    end_test();

    // Two stores to a and one to a + 4 before the loads, then a younger store to a
    start_test("store_forwarding");
    a  = random_addr();
    s0 = store_count;
    l0 = load_count;
    dispatch(op_store, 61'h400);
    dispatch(op_store, 61'h401);
    dispatch(op_store, 61'h402);
    dispatch(op_load, 61'h403);
    dispatch(op_load, 61'h404);
    dispatch(op_store, 61'h405);
    exec_store(s0, a, {$urandom, $urandom});
    exec_store(s0 + 1, a, {$urandom, $urandom});
    exec_store(s0 + 2, a + 61'h4, {$urandom, $urandom});
    exec_store(s0 + 3, a, {$urandom, $urandom});
    exec_load(l0, a);
    exec_load(l0 + 1, a + 61'h4);
    retire_load();
    retire_load();
    for (int i = 0; i < 4; i++) begin
      retire_store();
    end
    end_test();

    start_test("store_retire_to_memory");
    s0 = store_count;
    for (int i = 0; i < 4; i++) begin
      dispatch(op_store, 61'h500 + i);
    end
    for (int i = 0; i < 4; i++) begin
      exec_store(s0 + i, ADDR_BASE + i, {$urandom, $urandom});
    end
    for (int i = 0; i < 4; i++) begin
      retire_store();
    end
    for (int i = 0; i < 4; i++) begin
      l0 = load_count;
      dispatch(op_load, 61'h510 + i);
      exec_load(l0, ADDR_BASE + i);
      retire_load();
    end
    end_test();

    start_test("memory_order_violation");
    a  = random_addr();
    s0 = store_count;
    l0 = load_count;
    dispatch(op_store, 61'h600);
    dispatch(op_load, 61'h601);
    exec_load(l0, a);
    exec_store(s0, a, {$urandom, $urandom});
    retire_store();
    retire_load();
    // Same address again where the load forwards
    s0 = store_count;
    l0 = load_count;
    dispatch(op_store, 61'h610);
    exec_store(s0, a, {$urandom, $urandom});
    dispatch(op_load, 61'h611);
    exec_load(l0, a);
    retire_store();
    retire_load();
    end_test();

    end_run();
  end

endmodule

// File: lsq_top.sv
`timescale 1ns/1ns

module lsq_top #(
  parameter int SQ_DEPTH = 8,
  parameter int LQ_DEPTH = 8
) (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        dispatch_valid,
  input  mem_pkg::mem_op_e            dispatch_op,
  input  mem_pkg::addr_t              dispatch_pc,
  output logic                        dispatch_ready,
  output logic [$clog2(SQ_DEPTH)-1:0] sq_idx,
  output logic [$clog2(LQ_DEPTH)-1:0] lq_idx,
  input  logic                        st_exec,
  input  logic [$clog2(SQ_DEPTH)-1:0] st_exec_idx,
  input  mem_pkg::addr_t              st_addr,
  input  mem_pkg::data_t              st_data,
  input  logic                        ld_exec,
  input  logic [$clog2(LQ_DEPTH)-1:0] ld_exec_idx,
  input  mem_pkg::addr_t              ld_addr,
  output logic                        ld_done,
  output mem_pkg::data_t              ld_data,
  output logic                        ld_forwarded,
  output logic                        mem_rd_en,
  output mem_pkg::addr_t              mem_rd_addr,
  input  mem_pkg::data_t              mem_rd_data,
  input  logic                        store_retire,
  input  logic                        load_retire,
  output logic                        mem_wr_en,
  output mem_pkg::addr_t              mem_wr_addr,
  output mem_pkg::data_t              mem_wr_data,
  output logic                        violation,
  output mem_pkg::addr_t              violation_pc
);
  import mem_pkg::*;

  logic sq_full;
  logic lq_full;
  logic sq_alloc;
  logic lq_alloc;

  sq_lq_if #(
    .SQ_DEPTH (SQ_DEPTH)
  ) sq_lq ();

  // Combined ready, either queue full stalls dispatch
  assign dispatch_ready = !sq_full && !lq_full;
  assign sq_alloc = dispatch_valid && dispatch_ready && (dispatch_op == op_store);
  assign lq_alloc = dispatch_valid && dispatch_ready && (dispatch_op == op_load);

  store_queue #(
    .SQ_DEPTH (SQ_DEPTH)
  ) store_queue_inst (
    .clock        (clock),
    .reset        (reset),
    .alloc        (sq_alloc),
    .st_exec      (st_exec),
    .st_exec_idx  (st_exec_idx),
    .st_addr      (st_addr),
    .st_data      (st_data),
    .store_retire (store_retire),
    .full         (sq_full),
    .sq_idx       (sq_idx),
    .mem_wr_en    (mem_wr_en),
    .mem_wr_addr  (mem_wr_addr),
    .mem_wr_data  (mem_wr_data),
    .fwd          (sq_lq.sq)
  );

  load_queue #(
    .SQ_DEPTH (SQ_DEPTH),
    .LQ_DEPTH (LQ_DEPTH)
  ) load_queue_inst (
    .clock        (clock),
    .reset        (reset),
    .alloc        (lq_alloc),
    .dispatch_pc  (dispatch_pc),
    .ld_exec      (ld_exec),
    .ld_exec_idx  (ld_exec_idx),
    .ld_addr      (ld_addr),
    .load_retire  (load_retire),
    .mem_rd_data  (mem_rd_data),
    .full         (lq_full),
    .lq_idx       (lq_idx),
    .ld_done      (ld_done),
    .ld_data      (ld_data),
    .ld_forwarded (ld_forwarded),
    .mem_rd_en    (mem_rd_en),
    .mem_rd_addr  (mem_rd_addr),
    .violation    (violation),
    .violation_pc (violation_pc),
    .fwd          (sq_lq.lq)
  );

  a_dispatch_when_ready: assert property (
    @(posedge clock) disable iff (reset)
    dispatch_valid |-> dispatch_ready
  ) else $error("lsq_top: dispatch while not ready");

endmodule

// File: load_queue.sv
`timescale 1ns/1ns

module load_queue #(
  parameter int SQ_DEPTH = 8,
  parameter int LQ_DEPTH = 8
) (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        alloc,
  input  mem_pkg::addr_t              dispatch_pc,
  input  logic                        ld_exec,
  input  logic [$clog2(LQ_DEPTH)-1:0] ld_exec_idx,
  input  mem_pkg::addr_t              ld_addr,
  input  logic                        load_retire,
  input  mem_pkg::data_t              mem_rd_data,
  output logic                        full,
  output logic [$clog2(LQ_DEPTH)-1:0] lq_idx,
  output logic                        ld_done,
  output mem_pkg::data_t              ld_data,
  output logic                        ld_forwarded,
  output logic                        mem_rd_en,
  output mem_pkg::addr_t              mem_rd_addr,
  output logic                        violation,
  output mem_pkg::addr_t              violation_pc,
  sq_lq_if.lq                         fwd
);
  import lsq_pkg::*;

  localparam int LIW = $clog2(LQ_DEPTH);
  localparam int LPW = LIW + 1;
  localparam int SPW = $clog2(SQ_DEPTH) + 1;

  logic [LPW-1:0]    head;
  logic [LPW-1:0]    tail;
  logic [LPW-1:0]    live_count;
  logic [LIW-1:0]    tail_idx;
  logic [LIW-1:0]    slot_idx [LQ_DEPTH];
  logic [LQ_DEPTH-1:0] in_range;
  load_entry_t       loads [LQ_DEPTH];
  // SQ tail at dispatch, and the store a load forwarded from
  logic [SPW-1:0]    bound_tag [LQ_DEPTH];
  logic [SPW-1:0]    src_tag [LQ_DEPTH];

  queue_ptrs #(
    .DEPTH (LQ_DEPTH)
  ) ptrs_inst (
    .clock (clock),
    .reset (reset),
    .alloc (alloc),
    .free  (load_retire),
    .tail  (tail),
    .head  (head),
    .full  (full),
    .empty ()
  );

  assign tail_idx = tail[LIW-1:0];
  assign lq_idx   = tail_idx;

  // Forward request, memory read only on a miss
  assign fwd.fwd_addr  = ld_addr;
  assign fwd.fwd_bound = bound_tag[ld_exec_idx];
  assign ld_done       = ld_exec;
  assign ld_forwarded  = ld_exec && fwd.fwd_hit;
  assign mem_rd_en     = ld_exec && !fwd.fwd_hit;
  assign mem_rd_addr   = ld_addr;
  assign ld_data       = fwd.fwd_hit ? fwd.fwd_data : mem_rd_data;

  always_ff @(posedge clock) begin
    if (alloc) begin
      loads[tail_idx].pc       <= dispatch_pc;
      loads[tail_idx].executed <= 1'b0;
      bound_tag[tail_idx]      <= fwd.sq_tail;
    end
    if (ld_exec) begin
      loads[ld_exec_idx].addr     <= ld_addr;
      loads[ld_exec_idx].executed <= 1'b1;
      src_tag[ld_exec_idx]        <= fwd.fwd_tag;
      if (fwd.fwd_hit) begin
        loads[ld_exec_idx].src <= src_store;
      end else begin
        loads[ld_exec_idx].src <= src_memory;
      end
    end
  end

  assign live_count = tail - head;

  always_comb begin
    for (int j = 0; j < LQ_DEPTH; j++) begin
      slot_idx[j] = head[LIW-1:0] + LIW'(j);
      in_range[j] = (LPW'(j) < live_count);
    end
  end

  // Youngest first, so the oldest qualifying load is left at the end
  always_comb begin
    violation    = 1'b0;
    violation_pc = '0;
    for (int j = LQ_DEPTH - 1; j >= 0; j--) begin
      if (fwd.ret_valid && in_range[j] &&
          loads[slot_idx[j]].executed &&
          loads[slot_idx[j]].addr == fwd.ret_addr &&
          bound_tag[slot_idx[j]] != fwd.ret_tag &&
          !(loads[slot_idx[j]].src == src_store && src_tag[slot_idx[j]] == fwd.ret_tag)) begin
        violation    = 1'b1;
        violation_pc = loads[slot_idx[j]].pc;
      end
    end
  end

endmodule

// File: store_queue.sv
`timescale 1ns/1ns

module store_queue #(
  parameter int SQ_DEPTH = 8
) (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        alloc,
  input  logic                        st_exec,
  input  logic [$clog2(SQ_DEPTH)-1:0] st_exec_idx,
  input  mem_pkg::addr_t              st_addr,
  input  mem_pkg::data_t              st_data,
  input  logic                        store_retire,
  output logic                        full,
  output logic [$clog2(SQ_DEPTH)-1:0] sq_idx,
  output logic                        mem_wr_en,
  output mem_pkg::addr_t              mem_wr_addr,
  output mem_pkg::data_t              mem_wr_data,
  sq_lq_if.sq                         fwd
);
  import lsq_pkg::*;

  localparam int IW = $clog2(SQ_DEPTH);

  logic [IW:0]   head;
  logic [IW:0]   tail;
  logic          empty;
  logic [IW-1:0] head_idx;
  logic [IW-1:0] tail_idx;
  store_entry_t  entries [SQ_DEPTH];

  queue_ptrs #(
    .DEPTH (SQ_DEPTH)
  ) ptrs_inst (
    .clock (clock),
    .reset (reset),
    .alloc (alloc),
    .free  (store_retire),
    .tail  (tail),
    .head  (head),
    .full  (full),
    .empty (empty)
  );

  assign head_idx = head[IW-1:0];
  assign tail_idx = tail[IW-1:0];
  assign sq_idx   = tail_idx;

  always_ff @(posedge clock) begin
    if (alloc) begin
      entries[tail_idx].addr_valid <= 1'b0;
    end
    if (st_exec) begin
      entries[st_exec_idx] <= '{addr: st_addr, data: st_data, addr_valid: 1'b1};
    end
  end

  // Head store goes to memory in the retire cycle
  assign mem_wr_en   = store_retire;
  assign mem_wr_addr = entries[head_idx].addr;
  assign mem_wr_data = entries[head_idx].data;

  assign fwd.ret_valid = store_retire;
  assign fwd.ret_tag   = head;
  assign fwd.ret_addr  = entries[head_idx].addr;
  assign fwd.sq_tail   = tail;

  store_forward #(
    .DEPTH (SQ_DEPTH)
  ) forward_inst (
    .entries (entries),
    .head    (head),
    .bound   (fwd.fwd_bound),
    .addr    (fwd.fwd_addr),
    .hit     (fwd.fwd_hit),
    .data    (fwd.fwd_data),
    .tag     (fwd.fwd_tag)
  );

  a_retire_executed: assert property (
    @(posedge clock) disable iff (reset)
    store_retire |-> !empty && entries[head_idx].addr_valid
  ) else $error("store_queue: retiring a store that has not executed");

endmodule

// File: store_forward.sv
`timescale 1ns/1ns

module store_forward #(
  parameter int DEPTH = 8
) (
  input  lsq_pkg::store_entry_t    entries [DEPTH],
  input  logic [$clog2(DEPTH):0]   head,
  input  logic [$clog2(DEPTH):0]   bound,
  input  mem_pkg::addr_t           addr,
  output logic                     hit,
  output mem_pkg::data_t           data,
  output logic [$clog2(DEPTH):0]   tag
);

  localparam int IW = $clog2(DEPTH);
  localparam int PW = IW + 1;

  logic [PW-1:0]    older_count;
  logic [PW-1:0]    slot [DEPTH];
  logic [DEPTH-1:0] in_range;

  // Stores between head and the load's boundary are older than the load
  assign older_count = bound - head;

  always_comb begin
    for (int j = 0; j < DEPTH; j++) begin
      slot[j]     = head + PW'(j);
      in_range[j] = (PW'(j) < older_count);
    end
  end

  // Oldest to youngest, so the last match is the youngest
  always_comb begin
    hit  = 1'b0;
    data = '0;
    tag  = '0;
    for (int j = 0; j < DEPTH; j++) begin
      if (in_range[j] && entries[slot[j][IW-1:0]].addr_valid &&
          entries[slot[j][IW-1:0]].addr == addr) begin
        hit  = 1'b1;
        data = entries[slot[j][IW-1:0]].data;
        tag  = slot[j];
      end
    end
  end

endmodule

// File: queue_ptrs.sv
`timescale 1ns/1ns

module queue_ptrs #(
  parameter int DEPTH = 8
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 alloc,
  input  logic                 free,
  output logic [$clog2(DEPTH):0] tail,
  output logic [$clog2(DEPTH):0] head,
  output logic                 full,
  output logic                 empty
);

  localparam int IW = $clog2(DEPTH);

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
    end else begin
      if (alloc) begin
        tail <= tail + 1'b1;
      end
      if (free) begin
        head <= head + 1'b1;
      end
    end
  end

  // Same slot, wrap bits tell full from empty
  assign empty = (head == tail);
  assign full  = (head[IW-1:0] == tail[IW-1:0]) && (head[IW] != tail[IW]);

  a_no_alloc_when_full: assert property (
    @(posedge clock) disable iff (reset)
    alloc |-> !full
  ) else $error("queue_ptrs: alloc while full");

  a_no_free_when_empty: assert property (
    @(posedge clock) disable iff (reset)
    free |-> !empty
  ) else $error("queue_ptrs: free while empty");

endmodule

// File: sq_lq_if.sv
`timescale 1ns/1ns

interface sq_lq_if #(
  parameter int SQ_DEPTH = 8
);
  import mem_pkg::*;

  localparam int PW = $clog2(SQ_DEPTH) + 1;

  // Forwarding request and answer
  addr_t         fwd_addr;
  logic [PW-1:0] fwd_bound;
  logic          fwd_hit;
  data_t         fwd_data;
  logic [PW-1:0] fwd_tag;

  // Store leaving the head of the SQ
  logic          ret_valid;
  logic [PW-1:0] ret_tag;
  addr_t         ret_addr;

  logic [PW-1:0] sq_tail;

  modport sq (
    input  fwd_addr, fwd_bound,
    output fwd_hit, fwd_data, fwd_tag,
    output ret_valid, ret_tag, ret_addr,
    output sq_tail
  );

  modport lq (
    output fwd_addr, fwd_bound,
    input  fwd_hit, fwd_data, fwd_tag,
    input  ret_valid, ret_tag, ret_addr,
    input  sq_tail
  );

endinterface

// File: lsq_pkg.sv
package lsq_pkg;

  typedef struct packed {
    mem_pkg::addr_t addr;
    mem_pkg::data_t data;
    logic           addr_valid;
  } store_entry_t;

  // Where an executed load took its data from
  typedef enum logic {
    src_memory,
    src_store
  } load_src_e;

  typedef struct packed {
    mem_pkg::addr_t pc;
    mem_pkg::addr_t addr;
    logic           executed;
    load_src_e      src;
  } load_entry_t;

endpackage

// File: mem_pkg.sv
package mem_pkg;

  // 8-byte word address, byte address bits [63:3]
  typedef logic [60:0] addr_t;

  typedef logic [63:0] data_t;

  // Operation type presented at dispatch
  typedef enum logic [1:0] {
    op_none,
    op_load,
    op_store
  } mem_op_e;

endpackage
